// File: design/core_pkg.sv
package core_pkg;

   localparam int DATA_WIDTH     = 32;
   localparam int REG_ADDR_WIDTH = 5;
   localparam int LOAD_OP_WIDTH  = 3;

   // One architectural data word
   typedef logic [DATA_WIDTH-1:0] data_t;

   // Register file index, x0 to x31
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   // Load operation code, same as RISC-V funct3
   typedef logic [LOAD_OP_WIDTH-1:0] load_op_t;

   localparam load_op_t LOAD_LB  = 3'd0;  // Byte, sign extended
   localparam load_op_t LOAD_LH  = 3'd1;  // Half, sign extended
   localparam load_op_t LOAD_LW  = 3'd2;  // Full word
   localparam load_op_t LOAD_LBU = 3'd4;  // Byte, zero extended
   localparam load_op_t LOAD_LHU = 3'd5;  // Half, zero extended

endpackage

// File: design/mem_pkg.sv
package mem_pkg;

   localparam int MEM_ADDR_WIDTH     = 12;    // Byte address bits
   localparam int MEM_TRANSFER_WIDTH = 4;     // Byte lanes per word
   localparam int MEM_DEPTH          = 1024;  // Words in the data RAM

   // Byte address on the data bus
   typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

   // One enable per byte lane
   typedef logic [MEM_TRANSFER_WIDTH-1:0] mem_be_t;

endpackage

// File: design/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if;
   import core_pkg::*;
   import mem_pkg::*;

   logic      req;     // Access request
   logic      gnt;     // Request accepted this cycle
   logic      rvalid;  // Read data valid
   logic      wr;      // 1 for store, 0 for load
   mem_addr_t addr;
   data_t     wdata;
   mem_be_t   be;
   data_t     rdata;

   modport master (
      output req, wr, addr, wdata, be,
      input  gnt, rvalid, rdata
   );

   modport slave (
      input  req, wr, addr, wdata, be,
      output gnt, rvalid, rdata
   );

endinterface

// File: design/core_mem_stage.sv
`timescale 1ns/1ps

module core_mem_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  core_pkg::reg_addr_t m_regfile_waddr_i,
   input  logic                m_regfile_wr_i,
   input  core_pkg::data_t     m_regfile_rd_i,
   input  logic                m_data_rd_i,
   input  logic                m_data_wr_i,
   input  mem_pkg::mem_addr_t  m_data_addr_i,
   input  mem_pkg::mem_be_t    m_data_be_i,
   input  core_pkg::load_op_t  m_load_op_i,
   output logic                stall_o,
   data_bus_if.master          bus,
   output core_pkg::reg_addr_t w_regfile_waddr_o,
   output logic                w_regfile_wr_o,
   output core_pkg::data_t     w_regfile_rd_o,
   output logic                w_is_load_o,
   output core_pkg::load_op_t  w_load_op_o,
   output logic [1:0]          w_byte_off_o,
   output core_pkg::data_t     w_data_rdata_o
);

   typedef enum logic {
      IDLE,
      READ
   } mem_state_t;

   mem_state_t state;
   mem_state_t next_state;
   logic       access;  // M stage holds a load or store
   logic       accepted;

   assign access = m_data_rd_i | m_data_wr_i;

   // No new request while a granted read waits for its data
   assign bus.req   = access && (state == IDLE);
   assign bus.wr    = m_data_wr_i;
   assign bus.addr  = m_data_addr_i;
   assign bus.wdata = m_regfile_rd_i;  // Already placed in its byte lanes upstream
   assign bus.be    = m_data_be_i;

   assign accepted = bus.req && bus.gnt;

   // A store finishes at grant, a load only once rvalid comes back
   assign stall_o = (bus.req && !bus.gnt)
                  || (accepted && m_data_rd_i)
                  || ((state == READ) && !bus.rvalid);

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (accepted && m_data_rd_i)
               next_state = READ;
         end
         READ:
         begin
            if (bus.rvalid)
               next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= IDLE;
      else
         state <= next_state;
   end

   // M to W pipeline register
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         w_regfile_waddr_o <= '0;
         w_regfile_wr_o    <= 1'b0;
         w_regfile_rd_o    <= '0;
         w_is_load_o       <= 1'b0;
         w_load_op_o       <= '0;
         w_byte_off_o      <= 2'b00;
         w_data_rdata_o    <= '0;
      end
      else if (!stall_o)
      begin
         w_regfile_waddr_o <= m_regfile_waddr_i;
         w_regfile_wr_o    <= m_regfile_wr_i;
         w_regfile_rd_o    <= m_regfile_rd_i;
         w_is_load_o       <= m_data_rd_i;
         w_load_op_o       <= m_load_op_i;
         w_byte_off_o      <= m_data_addr_i[1:0];
         if (bus.rvalid)
            w_data_rdata_o <= bus.rdata;  // Load data lands with the load
      end
   end

   // The RAM only answers reads this stage is waiting for
   a_no_rvalid_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state == IDLE) |-> !bus.rvalid);

   a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(m_data_rd_i && m_data_wr_i));

   // A pending request must not change under the slave
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (bus.req && !bus.gnt) |=> bus.req && $stable(bus.addr) && $stable(bus.wr)
                                && $stable(bus.wdata) && $stable(bus.be));

endmodule

// File: design/core_wb_stage.sv
`timescale 1ns/1ps

module core_wb_stage (
   input  core_pkg::reg_addr_t w_regfile_waddr_i,
   input  logic                w_regfile_wr_i,
   input  core_pkg::data_t     w_regfile_rd_i,
   input  logic                w_is_load_i,
   input  core_pkg::load_op_t  w_load_op_i,
   input  logic [1:0]          w_byte_off_i,
   input  core_pkg::data_t     w_data_rdata_i,
   output logic                rf_we_o,
   output core_pkg::reg_addr_t rf_waddr_o,
   output core_pkg::data_t     rf_wdata_o
);
   import core_pkg::*;

   logic [7:0]  load_byte;
   logic [15:0] load_half;
   data_t       load_value;

   // Byte lane picked by the low address bits
   always_comb
   begin
      case (w_byte_off_i)
         2'd0:    load_byte = w_data_rdata_i[7:0];
         2'd1:    load_byte = w_data_rdata_i[15:8];
         2'd2:    load_byte = w_data_rdata_i[23:16];
         default: load_byte = w_data_rdata_i[31:24];
      endcase
   end

   // Halves are aligned, so only bit 1 matters
   assign load_half = w_byte_off_i[1] ? w_data_rdata_i[31:16] : w_data_rdata_i[15:0];

   always_comb
   begin
      case (w_load_op_i)
         LOAD_LB:
         begin
            load_value = {{(DATA_WIDTH-8){load_byte[7]}}, load_byte};
         end
         LOAD_LH:
         begin
            load_value = {{(DATA_WIDTH-16){load_half[15]}}, load_half};
         end
         LOAD_LBU:
         begin
            load_value = {{(DATA_WIDTH-8){1'b0}}, load_byte};
         end
         LOAD_LHU:
         begin
            load_value = {{(DATA_WIDTH-16){1'b0}}, load_half};
         end
         LOAD_LW:
         begin
            load_value = w_data_rdata_i;
         end
         default:
         begin
            load_value = w_data_rdata_i;  // Unknown codes act as LW
         end
      endcase
   end

   assign rf_we_o    = w_regfile_wr_i;
   assign rf_waddr_o = w_regfile_waddr_i;
   assign rf_wdata_o = w_is_load_i ? load_value : w_regfile_rd_i;

endmodule

// File: design/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                we_i,
   input  core_pkg::reg_addr_t waddr_i,
   input  core_pkg::data_t     wdata_i,
   input  core_pkg::reg_addr_t raddr_i,
   output core_pkg::data_t     rdata_o
);
   import core_pkg::*;

   // x0 is never written and keeps its reset value
   data_t regs [32];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end
      else if (we_i && (waddr_i != '0))
      begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign rdata_o = regs[raddr_i];

   // Holds even right after a write to x0 from write-back
   a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (raddr_i == '0) |-> (rdata_o == '0));

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps

module data_ram (
   input  logic      clk,
   input  logic      rst_n,
   data_bus_if.slave bus
);
   import core_pkg::*;
   import mem_pkg::*;

   data_t                     mem [MEM_DEPTH];
   logic [7:0]                lfsr;
   logic                      lfsr_fb;
   logic [MEM_ADDR_WIDTH-3:0] word_idx;
   logic                      rd_accept;
   logic                      wr_accept;

   initial
   begin
      for (int i = 0; i < MEM_DEPTH; i++)
         mem[i] = '0;
   end

   // Taps 8,6,5,4 give the full 255-state sequence
   assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

   // Grant about one cycle in four
   assign bus.gnt = bus.req && (lfsr[1:0] == 2'b00);

   assign word_idx  = bus.addr[MEM_ADDR_WIDTH-1:2];
   assign rd_accept = bus.req && bus.gnt && !bus.wr;
   assign wr_accept = bus.req && bus.gnt && bus.wr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr       <= 8'h5a;
         bus.rvalid <= 1'b0;
      end
      else
      begin
         lfsr       <= {lfsr[6:0], lfsr_fb};
         bus.rvalid <= rd_accept;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_accept)
      begin
         for (int b = 0; b < MEM_TRANSFER_WIDTH; b++)
         begin
            if (bus.be[b])
               mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
         end
      end
      if (rd_accept)
         bus.rdata <= mem[word_idx];
   end

   // Data comes back while the master holds off its next request
   a_rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
      rd_accept |=> bus.rvalid && !bus.req);

endmodule

// File: design/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
   input  logic                clk,
   input  logic                rst_n,
   input  core_pkg::reg_addr_t m_regfile_waddr_i,
   input  logic                m_regfile_wr_i,
   input  core_pkg::data_t     m_regfile_rd_i,
   input  logic                m_data_rd_i,
   input  logic                m_data_wr_i,
   input  mem_pkg::mem_addr_t  m_data_addr_i,
   input  mem_pkg::mem_be_t    m_data_be_i,
   input  core_pkg::load_op_t  m_load_op_i,
   output logic                stall_o,
   input  core_pkg::reg_addr_t rf_raddr_i,
   output core_pkg::data_t     rf_rdata_o
);
   import core_pkg::*;

   reg_addr_t  w_regfile_waddr;
   logic       w_regfile_wr;
   data_t      w_regfile_rd;
   logic       w_is_load;
   load_op_t   w_load_op;
   logic [1:0] w_byte_off;
   data_t      w_data_rdata;
   logic       rf_we;
   reg_addr_t  rf_waddr;
   data_t      rf_wdata;

   data_bus_if u_bus ();

   core_mem_stage u_mem_stage (
      .clk               (clk),
      .rst_n             (rst_n),
      .m_regfile_waddr_i (m_regfile_waddr_i),
      .m_regfile_wr_i    (m_regfile_wr_i),
      .m_regfile_rd_i    (m_regfile_rd_i),
      .m_data_rd_i       (m_data_rd_i),
      .m_data_wr_i       (m_data_wr_i),
      .m_data_addr_i     (m_data_addr_i),
      .m_data_be_i       (m_data_be_i),
      .m_load_op_i       (m_load_op_i),
      .stall_o           (stall_o),
      .bus               (u_bus.master),
      .w_regfile_waddr_o (w_regfile_waddr),
      .w_regfile_wr_o    (w_regfile_wr),
      .w_regfile_rd_o    (w_regfile_rd),
      .w_is_load_o       (w_is_load),
      .w_load_op_o       (w_load_op),
      .w_byte_off_o      (w_byte_off),
      .w_data_rdata_o    (w_data_rdata)
   );

   data_ram u_data_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (u_bus.slave)
   );

   core_wb_stage u_wb_stage (
      .w_regfile_waddr_i (w_regfile_waddr),
      .w_regfile_wr_i    (w_regfile_wr),
      .w_regfile_rd_i    (w_regfile_rd),
      .w_is_load_i       (w_is_load),
      .w_load_op_i       (w_load_op),
      .w_byte_off_i      (w_byte_off),
      .w_data_rdata_i    (w_data_rdata),
      .rf_we_o           (rf_we),
      .rf_waddr_o        (rf_waddr),
      .rf_wdata_o        (rf_wdata)
   );

   core_regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (rf_we),
      .waddr_i (rf_waddr),
      .wdata_i (rf_wdata),
      .raddr_i (rf_raddr_i),
      .rdata_o (rf_rdata_o)
   );

endmodule

// File: sim/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb;
   import core_pkg::*;
   import mem_pkg::*;

   localparam int MAX_CYCLES = 400 * 20;  // 400 instructions at 20 cycles each
   localparam int MIX_COUNT  = 300;

   logic        clk;
   logic        rst_n;
   reg_addr_t   m_regfile_waddr;
   logic        m_regfile_wr;
   data_t       m_regfile_rd;
   logic        m_data_rd;
   logic        m_data_wr;
   mem_addr_t   m_data_addr;
   mem_be_t     m_data_be;
   load_op_t    m_load_op;
   logic        stall;
   reg_addr_t   rf_raddr;
   data_t       rf_rdata;

   data_t       ref_mem [MEM_DEPTH];  // Reference state, updated in issue order
   data_t       ref_regs [32];
   load_op_t    load_ops [5];
   int          drain_count   = 0;
   int          compare_count = 0;
   int          cycle_count   = 0;
   logic [58:0] m_bundle;
   logic [58:0] m_held;
   logic        held_stall = 1'b0;

   mem_wb_top u_dut (
      .clk               (clk),
      .rst_n             (rst_n),
      .m_regfile_waddr_i (m_regfile_waddr),
      .m_regfile_wr_i    (m_regfile_wr),
      .m_regfile_rd_i    (m_regfile_rd),
      .m_data_rd_i       (m_data_rd),
      .m_data_wr_i       (m_data_wr),
      .m_data_addr_i     (m_data_addr),
      .m_data_be_i       (m_data_be),
      .m_load_op_i       (m_load_op),
      .stall_o           (stall),
      .rf_raddr_i        (rf_raddr),
      .rf_rdata_o        (rf_rdata)
   );

   assign m_bundle = {m_regfile_waddr, m_regfile_wr, m_regfile_rd, m_data_rd,
                      m_data_wr, m_data_addr, m_data_be, m_load_op};

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "Run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input data_t expected, input data_t actual);
      if (actual !== expected)
         abort_run($sformatf("ERR time=%0t %s expected=%08h actual=%08h",
                             $time, name, expected, actual));
   endtask

   // Extension rules of the RISC-V loads, applied to the aligned memory word
   function automatic data_t expected_load(data_t word, logic [1:0] off, load_op_t op);
      data_t shifted;
      shifted = word >> (8 * off);
      case (op)
         LOAD_LB:  return {{24{shifted[7]}}, shifted[7:0]};
         LOAD_LH:  return {{16{shifted[15]}}, shifted[15:0]};
         LOAD_LBU: return {24'd0, shifted[7:0]};
         LOAD_LHU: return {16'd0, shifted[15:0]};
         default:  return word;
      endcase
   endfunction

   task automatic set_bubble();
      m_regfile_waddr = '0;
      m_regfile_wr    = 1'b0;
      m_regfile_rd    = '0;
      m_data_rd       = 1'b0;
      m_data_wr       = 1'b0;
      m_data_addr     = '0;
      m_data_be       = '0;
      m_load_op       = LOAD_LW;
   endtask

   task automatic issue(input reg_addr_t rd, input logic rd_wr, input data_t value,
                        input logic ld, input logic st, input mem_addr_t addr,
                        input mem_be_t be, input load_op_t op);
      @(negedge clk);
      m_regfile_waddr = rd;
      m_regfile_wr    = rd_wr;
      m_regfile_rd    = value;
      m_data_rd       = ld;
      m_data_wr       = st;
      m_data_addr     = addr;
      m_data_be       = be;
      m_load_op       = op;
      #1;
      if (!ld && !st)
         check_value("stall_o", '0, data_t'(stall));  // Advances on the next edge
      else if (ld)
         check_value("stall_o", 32'd1, data_t'(stall));  // Waits at least for rvalid
      while (stall)  // Held until the stage lets it go
      begin
         @(negedge clk);
         #1;
      end
      if (st)
      begin
         for (int b = 0; b < 4; b++)
            if (be[b])
               ref_mem[addr[MEM_ADDR_WIDTH-1:2]][8*b +: 8] = value[8*b +: 8];
      end
      if (rd_wr && (rd != '0))
         ref_regs[rd] = ld ? expected_load(ref_mem[addr[MEM_ADDR_WIDTH-1:2]], addr[1:0], op)
                           : value;
   endtask

   task automatic write_result(input reg_addr_t rd, input data_t value);
      issue(rd, 1'b1, value, 1'b0, 1'b0, '0, '0, LOAD_LW);
   endtask

   task automatic store_data(input mem_addr_t addr, input mem_be_t be, input data_t value);
      issue('0, 1'b0, value, 1'b0, 1'b1, addr, be, LOAD_LW);
   endtask

   task automatic load_data(input reg_addr_t rd, input mem_addr_t addr, input load_op_t op);
      issue(rd, 1'b1, '0, 1'b1, 1'b0, addr, 4'hf, op);
   endtask

   task automatic drain_and_compare();
      @(negedge clk);
      set_bubble();
      @(posedge clk);  // Last instruction written from W
      drain_count++;
      wait (compare_count == drain_count);
   endtask

   task automatic alu_writes();
      for (int i = 0; i < 32; i++)
         write_result(reg_addr_t'(i), $urandom());  // x0 included
      drain_and_compare();
   endtask

   task automatic word_round_trip();
      for (int i = 0; i < 12; i++)
         store_data(mem_addr_t'(32'h100 + 4 * i), 4'hf, $urandom());
      for (int i = 0; i < 12; i++)
         load_data(reg_addr_t'(1 + i), mem_addr_t'(32'h100 + 4 * i), LOAD_LW);
      drain_and_compare();
   endtask

   task automatic byte_enable_stores();
      for (int i = 0; i < 8; i++)
      begin
         store_data(mem_addr_t'(32'h300 + 4 * i), 4'hf, $urandom());
         store_data(mem_addr_t'(32'h300 + 4 * i), mem_be_t'($urandom_range(15, 0)), $urandom());
      end
      for (int i = 0; i < 8; i++)
         load_data(reg_addr_t'(1 + i), mem_addr_t'(32'h300 + 4 * i), LOAD_LW);
      drain_and_compare();
   endtask

   task automatic subword_loads();
      data_t     patterns [4];
      mem_addr_t base;
      patterns[0] = 32'h80ff7f01;  // Sign edges in every lane
      patterns[1] = 32'h7fff8000;
      patterns[2] = $urandom();
      patterns[3] = $urandom();
      for (int w = 0; w < 4; w++)
      begin
         base = mem_addr_t'(32'h400 + 4 * w);
         store_data(base, 4'hf, patterns[w]);
         for (int off = 0; off < 4; off++)
         begin
            load_data(reg_addr_t'(1 + off), base + mem_addr_t'(off), LOAD_LB);
            load_data(reg_addr_t'(5 + off), base + mem_addr_t'(off), LOAD_LBU);
         end
         for (int h = 0; h < 2; h++)
         begin
            load_data(reg_addr_t'(9 + h), base + mem_addr_t'(2 * h), LOAD_LH);
            load_data(reg_addr_t'(11 + h), base + mem_addr_t'(2 * h), LOAD_LHU);
         end
         drain_and_compare();
      end
   endtask

   task automatic random_mix();
      int        kind;
      int        pick;
      mem_addr_t addr;
      load_op_t  op;
      logic [1:0] off;
      for (int n = 0; n < MIX_COUNT; n++)
      begin
         kind = $urandom_range(3, 0);
         addr = mem_addr_t'($urandom_range(63, 0) * 4);  // Small window so loads hit stores
         case (kind)
            0: write_result(reg_addr_t'($urandom_range(31, 0)), $urandom());
            1: store_data(addr, mem_be_t'($urandom_range(15, 0)), $urandom());
            2:
            begin
               pick = $urandom_range(4, 0);
               op   = load_ops[pick];
               if (op == LOAD_LW)
                  off = 2'd0;
               else if ((op == LOAD_LH) || (op == LOAD_LHU))
                  off = {1'($urandom_range(1, 0)), 1'b0};
               else
                  off = 2'($urandom_range(3, 0));
               load_data(reg_addr_t'($urandom_range(31, 0)), addr | mem_addr_t'(off), op);
            end
            default: issue(reg_addr_t'($urandom_range(31, 0)), 1'b0, $urandom(),
                           1'b0, 1'b0, '0, '0, LOAD_LW);  // Result without write flag
         endcase
      end
      drain_and_compare();
   endtask

   initial
   begin
      void'($urandom(32'h97cf));
      load_ops[0] = LOAD_LB;
      load_ops[1] = LOAD_LH;
      load_ops[2] = LOAD_LW;
      load_ops[3] = LOAD_LBU;
      load_ops[4] = LOAD_LHU;
      for (int i = 0; i < MEM_DEPTH; i++)
         ref_mem[i] = '0;
      for (int i = 0; i < 32; i++)
         ref_regs[i] = '0;
      rst_n = 1'b0;
      set_bubble();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      alu_writes();
      word_round_trip();
      byte_enable_stores();
      subword_loads();
      random_mix();
      $display("test passed");
      $finish;
   end

   // Reads back the whole register file after each drain
   initial
   begin
      rf_raddr = '0;
      forever
      begin
         wait (drain_count > compare_count);
         for (int i = 0; i < 32; i++)
         begin
            @(negedge clk);
            rf_raddr = reg_addr_t'(i);
            #1;
            check_value($sformatf("rf_rdata_o[x%0d]", i), ref_regs[i], rf_rdata);
         end
         compare_count++;
      end
   end

   // M inputs must hold while the stage stalls
   always @(posedge clk)
   begin
      if (rst_n && held_stall && (m_bundle !== m_held))
         abort_run("M-stage inputs changed while stall_o was high");
      held_stall = stall;
      m_held     = m_bundle;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > MAX_CYCLES)
         abort_run($sformatf("Timeout, tests did not finish within %0d cycles", MAX_CYCLES));
   end

endmodule

// File: tb.f
design/core_pkg.sv
design/mem_pkg.sv
design/data_bus_if.sv
design/core_mem_stage.sv
design/core_wb_stage.sv
design/core_regfile.sv
design/data_ram.sv
design/mem_wb_top.sv
sim/tb_mem_wb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mem_wb
FILELIST = tb.f
LOG      = sim.log
PASS_MSG = test passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
